// ==== mips_ex_isa_pkg.sv ====
// ISA definitions for the execute stage: opcodes, function codes, ALU codes and instruction views
`default_nettype none

package mips_ex_isa_pkg;

	// ==============================
	// primary opcodes
	// ==============================
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_BLEZ  = 6'h06,
		OP_BGTZ  = 6'h07,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_ADD  = 6'h20,
		F_SUB  = 6'h22,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	// ==============================
	// ALU operation codes
	// ==============================
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_NOR   = 4'd5,
		ALU_SLT   = 4'd6,
		ALU_SLTU  = 4'd7,
		ALU_SLL   = 4'd8,
		ALU_SRL   = 4'd9,
		ALU_SRA   = 4'd10,
		ALU_LUI   = 4'd11,
		ALU_PASSA = 4'd12
	} alu_op_e;

	// register format
	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	// immediate format
	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one word, two ways to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

`default_nettype wire

// ==== mips_ex_ctl_pkg.sv ====
// Pipeline control codes shared by the decoder, forwarding unit and execute stage
`default_nettype none

package mips_ex_ctl_pkg;

	// operand source for the execute stage muxes
	typedef enum logic [1:0] {
		// register file read
		FWD_REG   = 2'd0,
		// ALU result one ahead
		FWD_EXMEM = 2'd1,
		// load data one ahead
		FWD_MEMLD = 2'd2,
		// writeback value two ahead
		FWD_MEMWB = 2'd3
	} fwd_sel_e;

	// branch conditions
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4
	} br_cond_e;

	// return address register written by jal
	localparam logic [4:0] LINK_REG = 5'd31;

endpackage

`default_nettype wire

// ==== ex_instr_decoder.sv ====
// Combinational instruction decoder that produces the execute, memory and writeback controls
`timescale 1ns/1ps
`default_nettype none

module ex_instr_decoder (
	input  mips_ex_isa_pkg::instr_u   i_instr,
	input  logic                      i_valid,
	output mips_ex_isa_pkg::alu_op_e  o_alu_op,
	output logic                      o_alu_src_imm,
	output logic                      o_imm_zero_ext,
	output logic                      o_reg_dst_rd,
	output logic                      o_link,
	output logic                      o_mem_read,
	output logic                      o_mem_write,
	output logic                      o_mem_to_reg,
	output logic                      o_reg_write,
	output mips_ex_ctl_pkg::br_cond_e o_br_cond
);

	always_comb begin
		// bubble defaults
		o_alu_op       = mips_ex_isa_pkg::ALU_ADD;
		o_alu_src_imm  = 1'b0;
		o_imm_zero_ext = 1'b0;
		o_reg_dst_rd   = 1'b0;
		o_link         = 1'b0;
		o_mem_read     = 1'b0;
		o_mem_write    = 1'b0;
		o_mem_to_reg   = 1'b0;
		o_reg_write    = 1'b0;
		o_br_cond      = mips_ex_ctl_pkg::BR_NONE;
		if (i_valid) begin
			case (i_instr.i.op)
				mips_ex_isa_pkg::OP_RTYPE: begin
					o_reg_dst_rd = 1'b1;
					o_reg_write  = 1'b1;
					case (i_instr.r.funct)
						mips_ex_isa_pkg::F_ADD:  o_alu_op = mips_ex_isa_pkg::ALU_ADD;
						mips_ex_isa_pkg::F_SUB:  o_alu_op = mips_ex_isa_pkg::ALU_SUB;
						mips_ex_isa_pkg::F_AND:  o_alu_op = mips_ex_isa_pkg::ALU_AND;
						mips_ex_isa_pkg::F_OR:   o_alu_op = mips_ex_isa_pkg::ALU_OR;
						mips_ex_isa_pkg::F_XOR:  o_alu_op = mips_ex_isa_pkg::ALU_XOR;
						mips_ex_isa_pkg::F_NOR:  o_alu_op = mips_ex_isa_pkg::ALU_NOR;
						mips_ex_isa_pkg::F_SLT:  o_alu_op = mips_ex_isa_pkg::ALU_SLT;
						mips_ex_isa_pkg::F_SLTU: o_alu_op = mips_ex_isa_pkg::ALU_SLTU;
						mips_ex_isa_pkg::F_SLL:  o_alu_op = mips_ex_isa_pkg::ALU_SLL;
						mips_ex_isa_pkg::F_SRL:  o_alu_op = mips_ex_isa_pkg::ALU_SRL;
						mips_ex_isa_pkg::F_SRA:  o_alu_op = mips_ex_isa_pkg::ALU_SRA;
						default: begin
							// unknown funct acts as a bubble
							o_reg_dst_rd = 1'b0;
							o_reg_write  = 1'b0;
						end
					endcase
				end
				mips_ex_isa_pkg::OP_ADDI: begin
					o_alu_src_imm = 1'b1;
					o_reg_write   = 1'b1;
				end
				mips_ex_isa_pkg::OP_SLTI: begin
					o_alu_op      = mips_ex_isa_pkg::ALU_SLT;
					o_alu_src_imm = 1'b1;
					o_reg_write   = 1'b1;
				end
				mips_ex_isa_pkg::OP_ANDI: begin
					o_alu_op       = mips_ex_isa_pkg::ALU_AND;
					o_alu_src_imm  = 1'b1;
					o_imm_zero_ext = 1'b1;
					o_reg_write    = 1'b1;
				end
				mips_ex_isa_pkg::OP_ORI: begin
					o_alu_op       = mips_ex_isa_pkg::ALU_OR;
					o_alu_src_imm  = 1'b1;
					o_imm_zero_ext = 1'b1;
					o_reg_write    = 1'b1;
				end
				mips_ex_isa_pkg::OP_LUI: begin
					o_alu_op      = mips_ex_isa_pkg::ALU_LUI;
					o_alu_src_imm = 1'b1;
					o_reg_write   = 1'b1;
				end
				mips_ex_isa_pkg::OP_LW: begin
					o_alu_src_imm = 1'b1;
					o_mem_read    = 1'b1;
					o_mem_to_reg  = 1'b1;
					o_reg_write   = 1'b1;
				end
				mips_ex_isa_pkg::OP_SW: begin
					o_alu_src_imm = 1'b1;
					o_mem_write   = 1'b1;
				end
				mips_ex_isa_pkg::OP_BEQ:  o_br_cond = mips_ex_ctl_pkg::BR_EQ;
				mips_ex_isa_pkg::OP_BNE:  o_br_cond = mips_ex_ctl_pkg::BR_NE;
				mips_ex_isa_pkg::OP_BLEZ: o_br_cond = mips_ex_ctl_pkg::BR_LEZ;
				mips_ex_isa_pkg::OP_BGTZ: o_br_cond = mips_ex_ctl_pkg::BR_GTZ;
				mips_ex_isa_pkg::OP_JAL: begin
					// only the link write is handled here
					o_alu_op    = mips_ex_isa_pkg::ALU_PASSA;
					o_link      = 1'b1;
					o_reg_write = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== ex_forward_unit.sv ====
// Forwarding control that picks each execute operand's source from the in-flight destinations
`timescale 1ns/1ps
`default_nettype none

module ex_forward_unit (
	input  logic [4:0]                i_rs_addr,
	input  logic [4:0]                i_rt_addr,
	input  logic [4:0]                i_exmem_rd,
	input  logic                      i_exmem_regwrite,
	input  logic                      i_exmem_memread,
	input  logic [4:0]                i_memwb_rd,
	input  logic                      i_memwb_regwrite,
	output mips_ex_ctl_pkg::fwd_sel_e o_fwd_a,
	output mips_ex_ctl_pkg::fwd_sel_e o_fwd_b
);

	// newest producer wins, r0 is never forwarded
	function automatic mips_ex_ctl_pkg::fwd_sel_e pick_fwd(
		input logic [4:0] src,
		input logic [4:0] exmem_rd,
		input logic       exmem_we,
		input logic       exmem_ld,
		input logic [4:0] memwb_rd,
		input logic       memwb_we
	);
		if (src == 5'd0) begin
			pick_fwd = mips_ex_ctl_pkg::FWD_REG;
		end else if (exmem_we && exmem_rd == src) begin
			// a load one ahead has its data on the memory port right now
			pick_fwd = exmem_ld ? mips_ex_ctl_pkg::FWD_MEMLD : mips_ex_ctl_pkg::FWD_EXMEM;
		end else if (memwb_we && memwb_rd == src) begin
			pick_fwd = mips_ex_ctl_pkg::FWD_MEMWB;
		end else begin
			pick_fwd = mips_ex_ctl_pkg::FWD_REG;
		end
	endfunction

	always_comb begin
		o_fwd_a = pick_fwd(i_rs_addr, i_exmem_rd, i_exmem_regwrite, i_exmem_memread,
			i_memwb_rd, i_memwb_regwrite);
		o_fwd_b = pick_fwd(i_rt_addr, i_exmem_rd, i_exmem_regwrite, i_exmem_memread,
			i_memwb_rd, i_memwb_regwrite);
	end

	// ==============================
	// checks
	// ==============================
	// stale writeback value must never shadow the newer producer
	always_comb begin
		if (i_exmem_regwrite && i_exmem_rd != 5'd0) begin
			if (i_exmem_rd == i_rs_addr) begin
				assert (o_fwd_a != mips_ex_ctl_pkg::FWD_MEMWB)
				else $error("operand a forwarded from writeback over a newer producer");
			end
			if (i_exmem_rd == i_rt_addr) begin
				assert (o_fwd_b != mips_ex_ctl_pkg::FWD_MEMWB)
				else $error("operand b forwarded from writeback over a newer producer");
			end
		end
	end

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
// 32-bit ALU for arithmetic, logic, shift, compare, lui and link pass-through
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  logic [31:0]              i_a,
	input  logic [31:0]              i_b,
	input  logic [4:0]               i_shamt,
	input  mips_ex_isa_pkg::alu_op_e i_op,
	output logic [31:0]              o_result
);

	always_comb begin
		case (i_op)
			// add and sub wrap, no overflow trap
			mips_ex_isa_pkg::ALU_ADD: o_result = i_a + i_b;
			mips_ex_isa_pkg::ALU_SUB: o_result = i_a - i_b;
			mips_ex_isa_pkg::ALU_AND: o_result = i_a & i_b;
			mips_ex_isa_pkg::ALU_OR:  o_result = i_a | i_b;
			mips_ex_isa_pkg::ALU_XOR: o_result = i_a ^ i_b;
			mips_ex_isa_pkg::ALU_NOR: o_result = ~(i_a | i_b);
			mips_ex_isa_pkg::ALU_SLT: begin
				o_result = {31'd0, $signed(i_a) < $signed(i_b)};
			end
			mips_ex_isa_pkg::ALU_SLTU: begin
				o_result = {31'd0, i_a < i_b};
			end
			// shifts work on the rt operand
			mips_ex_isa_pkg::ALU_SLL: o_result = i_b << i_shamt;
			mips_ex_isa_pkg::ALU_SRL: o_result = i_b >> i_shamt;
			mips_ex_isa_pkg::ALU_SRA: o_result = $unsigned($signed(i_b) >>> i_shamt);
			mips_ex_isa_pkg::ALU_LUI: o_result = {i_b[15:0], 16'h0000};
			// link value
			mips_ex_isa_pkg::ALU_PASSA: o_result = i_a;
			default: o_result = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// ==== ex_branch_compare.sv ====
// Branch condition evaluation on the forwarded execute operands
`timescale 1ns/1ps
`default_nettype none

module ex_branch_compare (
	input  logic [31:0]               i_a,
	input  logic [31:0]               i_b,
	input  mips_ex_ctl_pkg::br_cond_e i_cond,
	output logic                      o_taken
);

	logic equal;
	logic a_zero;
	logic a_neg;

	assign equal  = (i_a == i_b);
	assign a_zero = (i_a == 32'd0);
	assign a_neg  = i_a[31];

	always_comb begin
		case (i_cond)
			mips_ex_ctl_pkg::BR_EQ:  o_taken = equal;
			mips_ex_ctl_pkg::BR_NE:  o_taken = !equal;
			// sign and zero tests look at rs only
			mips_ex_ctl_pkg::BR_LEZ: o_taken = a_neg || a_zero;
			mips_ex_ctl_pkg::BR_GTZ: o_taken = !a_neg && !a_zero;
			default:                 o_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
// Execute stage with operand muxes, ALU, branch compare and the execute/memory register
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic                      i_clk,
	input  logic                      i_nrst,
	input  mips_ex_isa_pkg::instr_u   i_instr,
	input  logic [31:0]               i_rs_data,
	input  logic [31:0]               i_rt_data,
	input  logic [31:0]               i_pc4,
	input  mips_ex_isa_pkg::alu_op_e  i_alu_op,
	input  logic                      i_alu_src_imm,
	input  logic                      i_imm_zero_ext,
	input  logic                      i_reg_dst_rd,
	input  logic                      i_link,
	input  logic                      i_mem_read,
	input  logic                      i_mem_write,
	input  logic                      i_mem_to_reg,
	input  logic                      i_reg_write,
	input  mips_ex_ctl_pkg::br_cond_e i_br_cond,
	input  mips_ex_ctl_pkg::fwd_sel_e i_fwd_a,
	input  mips_ex_ctl_pkg::fwd_sel_e i_fwd_b,
	input  logic [31:0]               i_memwb_data,
	input  logic [31:0]               i_mem_rdata,
	output logic [31:0]               o_alu_result,
	output logic [31:0]               o_store_data,
	output logic [4:0]                o_dest,
	output logic                      o_mem_read,
	output logic                      o_mem_write,
	output logic                      o_mem_to_reg,
	output logic                      o_reg_write,
	output logic                      o_branch_taken
);

	logic [31:0] opd_a;
	logic [31:0] opd_b;
	logic [31:0] imm_ext;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	logic [4:0]  dest;

	// four-way operand source mux
	function automatic logic [31:0] pick_src(
		input mips_ex_ctl_pkg::fwd_sel_e sel,
		input logic [31:0]               reg_val,
		input logic [31:0]               exmem_val,
		input logic [31:0]               memld_val,
		input logic [31:0]               memwb_val
	);
		case (sel)
			mips_ex_ctl_pkg::FWD_EXMEM: pick_src = exmem_val;
			mips_ex_ctl_pkg::FWD_MEMLD: pick_src = memld_val;
			mips_ex_ctl_pkg::FWD_MEMWB: pick_src = memwb_val;
			default:                    pick_src = reg_val;
		endcase
	endfunction

	// ==============================
	// operand and destination select
	// ==============================
	always_comb begin
		opd_a = pick_src(i_fwd_a, i_rs_data, o_alu_result, i_mem_rdata, i_memwb_data);
		opd_b = pick_src(i_fwd_b, i_rt_data, o_alu_result, i_mem_rdata, i_memwb_data);
		if (i_imm_zero_ext) begin
			imm_ext = {16'h0000, i_instr.i.imm};
		end else begin
			imm_ext = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
		end
		// jal sends its return address through pass-A
		alu_a = i_link ? i_pc4 : opd_a;
		alu_b = i_alu_src_imm ? imm_ext : opd_b;
		if (i_link) begin
			dest = mips_ex_ctl_pkg::LINK_REG;
		end else if (i_reg_dst_rd) begin
			dest = i_instr.r.rd;
		end else begin
			dest = i_instr.i.rt;
		end
	end

	ex_alu u_alu (
		.i_a      (alu_a),
		.i_b      (alu_b),
		.i_shamt  (i_instr.r.shamt),
		.i_op     (i_alu_op),
		.o_result (alu_y)
	);

	// branch decision uses forwarded registers, not the immediate
	ex_branch_compare u_branch_compare (
		.i_a     (opd_a),
		.i_b     (opd_b),
		.i_cond  (i_br_cond),
		.o_taken (o_branch_taken)
	);

	// ==============================
	// execute/memory register
	// ==============================
	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_alu_result <= 32'd0;
			o_store_data <= 32'd0;
			o_dest       <= 5'd0;
			o_mem_read   <= 1'b0;
			o_mem_write  <= 1'b0;
			o_mem_to_reg <= 1'b0;
			o_reg_write  <= 1'b0;
		end else begin
			o_alu_result <= alu_y;
			o_store_data <= opd_b;
			o_dest       <= dest;
			o_mem_read   <= i_mem_read;
			o_mem_write  <= i_mem_write;
			o_mem_to_reg <= i_mem_to_reg;
			o_reg_write  <= i_reg_write;
		end
	end

	// memory port carries one access per cycle
	a_no_rd_wr : assert property (
		@(posedge i_clk) disable iff (!i_nrst) !(o_mem_read && o_mem_write)
	) else $error("memory read and write registered together");

endmodule

`default_nettype wire

// ==== ex_mem_wb_regs.sv ====
// Memory/writeback register that selects load data or ALU result and drives the writeback bus
`timescale 1ns/1ps
`default_nettype none

module ex_mem_wb_regs (
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic [31:0] i_alu_result,
	input  logic [31:0] i_mem_rdata,
	input  logic [4:0]  i_dest,
	input  logic        i_mem_to_reg,
	input  logic        i_reg_write,
	output logic [31:0] o_wb_data,
	output logic [4:0]  o_wb_dest,
	output logic        o_wb_regwrite
);

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_wb_data     <= 32'd0;
			o_wb_dest     <= 5'd0;
			o_wb_regwrite <= 1'b0;
		end else begin
			// load data arrives in the same cycle as the read
			o_wb_data     <= i_mem_to_reg ? i_mem_rdata : i_alu_result;
			o_wb_dest     <= i_dest;
			// r0 stays hardwired to zero
			o_wb_regwrite <= i_reg_write && (i_dest != 5'd0);
		end
	end

	a_no_r0_write : assert property (
		@(posedge i_clk) disable iff (!i_nrst) !(o_wb_regwrite && o_wb_dest == 5'd0)
	) else $error("writeback to register 0");

endmodule

`default_nettype wire

// ==== ex_top.sv ====
// Top level of the execute subsystem, from instruction input to memory port and writeback bus
`timescale 1ns/1ps
`default_nettype none

module ex_top (
	input  logic                    i_clk,
	input  logic                    i_nrst,
	input  logic                    i_valid,
	input  mips_ex_isa_pkg::instr_u i_instr,
	input  logic [31:0]             i_rs_data,
	input  logic [31:0]             i_rt_data,
	input  logic [31:0]             i_pc4,
	input  logic [31:0]             i_mem_rdata,
	output logic [31:0]             o_mem_addr,
	output logic [31:0]             o_mem_wdata,
	output logic                    o_mem_read,
	output logic                    o_mem_write,
	output logic                    o_wb_regwrite,
	output logic [4:0]              o_wb_addr,
	output logic [31:0]             o_wb_data,
	output logic                    o_branch_taken
);

	// decoder controls
	mips_ex_isa_pkg::alu_op_e  alu_op;
	logic                      alu_src_imm;
	logic                      imm_zero_ext;
	logic                      reg_dst_rd;
	logic                      link;
	logic                      dec_mem_read;
	logic                      dec_mem_write;
	logic                      dec_mem_to_reg;
	logic                      dec_reg_write;
	mips_ex_ctl_pkg::br_cond_e br_cond;

	// forwarding and pipeline feedback
	mips_ex_ctl_pkg::fwd_sel_e fwd_a;
	mips_ex_ctl_pkg::fwd_sel_e fwd_b;
	logic [4:0]                exmem_dest;
	logic                      exmem_mem_to_reg;
	logic                      exmem_reg_write;

	ex_instr_decoder u_decoder (
		.i_instr        (i_instr),
		.i_valid        (i_valid),
		.o_alu_op       (alu_op),
		.o_alu_src_imm  (alu_src_imm),
		.o_imm_zero_ext (imm_zero_ext),
		.o_reg_dst_rd   (reg_dst_rd),
		.o_link         (link),
		.o_mem_read     (dec_mem_read),
		.o_mem_write    (dec_mem_write),
		.o_mem_to_reg   (dec_mem_to_reg),
		.o_reg_write    (dec_reg_write),
		.o_br_cond      (br_cond)
	);

	ex_forward_unit u_forward (
		.i_rs_addr        (i_instr.r.rs),
		.i_rt_addr        (i_instr.r.rt),
		.i_exmem_rd       (exmem_dest),
		.i_exmem_regwrite (exmem_reg_write),
		.i_exmem_memread  (o_mem_read),
		.i_memwb_rd       (o_wb_addr),
		.i_memwb_regwrite (o_wb_regwrite),
		.o_fwd_a          (fwd_a),
		.o_fwd_b          (fwd_b)
	);

	ex_stage u_ex_stage (
		.i_clk          (i_clk),
		.i_nrst         (i_nrst),
		.i_instr        (i_instr),
		.i_rs_data      (i_rs_data),
		.i_rt_data      (i_rt_data),
		.i_pc4          (i_pc4),
		.i_alu_op       (alu_op),
		.i_alu_src_imm  (alu_src_imm),
		.i_imm_zero_ext (imm_zero_ext),
		.i_reg_dst_rd   (reg_dst_rd),
		.i_link         (link),
		.i_mem_read     (dec_mem_read),
		.i_mem_write    (dec_mem_write),
		.i_mem_to_reg   (dec_mem_to_reg),
		.i_reg_write    (dec_reg_write),
		.i_br_cond      (br_cond),
		.i_fwd_a        (fwd_a),
		.i_fwd_b        (fwd_b),
		.i_memwb_data   (o_wb_data),
		.i_mem_rdata    (i_mem_rdata),
		.o_alu_result   (o_mem_addr),
		.o_store_data   (o_mem_wdata),
		.o_dest         (exmem_dest),
		.o_mem_read     (o_mem_read),
		.o_mem_write    (o_mem_write),
		.o_mem_to_reg   (exmem_mem_to_reg),
		.o_reg_write    (exmem_reg_write),
		.o_branch_taken (o_branch_taken)
	);

	ex_mem_wb_regs u_mem_wb (
		.i_clk         (i_clk),
		.i_nrst        (i_nrst),
		.i_alu_result  (o_mem_addr),
		.i_mem_rdata   (i_mem_rdata),
		.i_dest        (exmem_dest),
		.i_mem_to_reg  (exmem_mem_to_reg),
		.i_reg_write   (exmem_reg_write),
		.o_wb_data     (o_wb_data),
		.o_wb_dest     (o_wb_addr),
		.o_wb_regwrite (o_wb_regwrite)
	);

endmodule

`default_nettype wire

// ==== tb_ex_top.sv ====
// Testbench for ex_top that replays ex_top_trace.txt and checks memory port, writeback and branch flag
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

	localparam int FIELDS    = 15;
	localparam int MAX_LINES = 40;
	localparam int PERIOD    = 4;

	logic        i_clk;
	logic        i_nrst;
	logic        i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_rs_data;
	logic [31:0] i_rt_data;
	logic [31:0] i_pc4;
	logic [31:0] i_mem_rdata;
	logic [31:0] o_mem_addr;
	logic [31:0] o_mem_wdata;
	logic        o_mem_read;
	logic        o_mem_write;
	logic        o_wb_regwrite;
	logic [4:0]  o_wb_addr;
	logic [31:0] o_wb_data;
	logic        o_branch_taken;

	// trace words, FIELDS per line
	logic [31:0] trace_mem [0:FIELDS*MAX_LINES-1];
	int          n_lines;
	int          n_checks;
	int          n_errors;
	logic [16:0] lfsr;
	// trace line one and two cycles ahead, -1 for a bubble
	int          slot_mem;
	int          slot_wb;

	ex_top i_dut (
		.i_clk          (i_clk),
		.i_nrst         (i_nrst),
		.i_valid        (i_valid),
		.i_instr        (i_instr),
		.i_rs_data      (i_rs_data),
		.i_rt_data      (i_rt_data),
		.i_pc4          (i_pc4),
		.i_mem_rdata    (i_mem_rdata),
		.o_mem_addr     (o_mem_addr),
		.o_mem_wdata    (o_mem_wdata),
		.o_mem_read     (o_mem_read),
		.o_mem_write    (o_mem_write),
		.o_wb_regwrite  (o_wb_regwrite),
		.o_wb_addr      (o_wb_addr),
		.o_wb_data      (o_wb_data),
		.o_branch_taken (o_branch_taken)
	);

	always #(PERIOD / 2) i_clk = ~i_clk;

	// ==============================
	// helpers
	// ==============================
	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		lfsr_next = {s[15:0], s[16] ^ s[13]};
	endfunction

	// column order: g v instr rs rt pc4 ld br rd wr addr wdata we wa wd
	function automatic logic [31:0] trace_field(input int line, input int col);
		trace_field = trace_mem[line * FIELDS + col];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_trace();
		// unused words can never look like a group flag
		for (int a = 0; a < FIELDS * MAX_LINES; a++) begin
			trace_mem[a] = 32'hf000_0000 | 32'(a);
		end
		$readmemh("ex_top_trace.txt", trace_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && trace_field(n_lines, 0) <= 32'd1) begin
			n_lines++;
		end
	endtask

	// branch flag of the line presented in this cycle
	task automatic sample_branch_flag(input int idx);
		logic [31:0] exp_br;
		exp_br = (idx < 0) ? 32'd0 : trace_field(idx, 7);
		compare_value("o_branch_taken", 32'(o_branch_taken), exp_br);
	endtask

	// memory port of the line presented one cycle ago
	task automatic inspect_memory_port(input int idx);
		logic [31:0] exp_rd;
		logic [31:0] exp_wr;
		exp_rd = (idx < 0) ? 32'd0 : trace_field(idx, 8);
		exp_wr = (idx < 0) ? 32'd0 : trace_field(idx, 9);
		compare_value("o_mem_read", 32'(o_mem_read), exp_rd);
		compare_value("o_mem_write", 32'(o_mem_write), exp_wr);
		if (exp_rd[0] || exp_wr[0]) begin
			compare_value("o_mem_addr", o_mem_addr, trace_field(idx, 10));
		end
		if (exp_wr[0]) begin
			compare_value("o_mem_wdata", o_mem_wdata, trace_field(idx, 11));
		end
	endtask

	// writeback bus of the line presented two cycles ago
	task automatic confirm_writeback(input int idx);
		logic [31:0] exp_we;
		exp_we = (idx < 0) ? 32'd0 : trace_field(idx, 12);
		compare_value("o_wb_regwrite", 32'(o_wb_regwrite), exp_we);
		if (exp_we[0]) begin
			compare_value("o_wb_addr", 32'(o_wb_addr), trace_field(idx, 13));
			compare_value("o_wb_data", o_wb_data, trace_field(idx, 14));
		end
	endtask

	// one falling edge: check what is due, then present the next line
	task automatic step_slot(input int idx);
		@(negedge i_clk);
		inspect_memory_port(slot_mem);
		confirm_writeback(slot_wb);
		// load data answers the read now on the memory port
		i_mem_rdata = (slot_mem < 0) ? 32'd0 : trace_field(slot_mem, 6);
		if (idx < 0) begin
			i_valid   = 1'b0;
			i_instr   = 32'd0;
			i_rs_data = 32'd0;
			i_rt_data = 32'd0;
			i_pc4     = 32'd0;
		end else begin
			i_valid   = (trace_field(idx, 1) != 32'd0);
			i_instr   = trace_field(idx, 2);
			i_rs_data = trace_field(idx, 3);
			i_rt_data = trace_field(idx, 4);
			i_pc4     = trace_field(idx, 5);
		end
		// branch flag follows the forwarded operands before the next rising edge
		#(PERIOD / 4);
		sample_branch_flag(idx);
		slot_wb  = slot_mem;
		slot_mem = idx;
	endtask

	// random gap of 0 to 3 extra bubbles, one LFSR step per bit
	task automatic pad_bubbles();
		int n;
		n = 0;
		lfsr = lfsr_next(lfsr);
		n = n + int'(lfsr[0]);
		lfsr = lfsr_next(lfsr);
		n = n + 2 * int'(lfsr[0]);
		repeat (n) step_slot(-1);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		int group;
		int group_checks;
		int group_errors;
		i_clk       = 1'b0;
		i_nrst      = 1'b0;
		i_valid     = 1'b0;
		i_instr     = 32'd0;
		i_rs_data   = 32'd0;
		i_rt_data   = 32'd0;
		i_pc4       = 32'd0;
		i_mem_rdata = 32'd0;
		n_checks    = 0;
		n_errors    = 0;
		lfsr        = 17'd71379;
		slot_mem    = -1;
		slot_wb     = -1;
		load_trace();
		if (n_lines == 0) begin
			n_errors++;
			$display("trace file could not be read or holds no instructions");
		end
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_nrst = 1'b1;
		compare_value("o_mem_read", 32'(o_mem_read), 32'd0);
		compare_value("o_mem_write", 32'(o_mem_write), 32'd0);
		compare_value("o_wb_regwrite", 32'(o_wb_regwrite), 32'd0);
		compare_value("o_wb_data", o_wb_data, 32'd0);
		$display("test reset state: %0d checks, %0d errors", n_checks, n_errors);
		group        = 0;
		group_checks = n_checks;
		group_errors = n_errors;
		for (int line = 0; line < n_lines; line++) begin
			step_slot(line);
			if (trace_field(line, 0) != 32'd0) begin
				// two bubbles drain the group before it is reported
				step_slot(-1);
				step_slot(-1);
				group++;
				$display("test trace group %0d: %0d checks, %0d errors", group,
					n_checks - group_checks, n_errors - group_errors);
				group_checks = n_checks;
				group_errors = n_errors;
				pad_bubbles();
			end
		end
		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// worst case six slots per line, plus reset and margin
	initial begin
		wait (n_lines > 0);
		#((n_lines * 6 + 20) * PERIOD);
		$display("timeout: the trace did not finish in the expected time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_top_trace.txt ====
// g v instr rs_data rt_data pc4 ld_data br mem_rd mem_wr mem_addr mem_wdata wb_we wb_addr wb_data
// g=1 closes a group, ld_data returns one cycle after its line, hex throughout
// R-type add sub nor slt sltu sra sll
0 1 00225020 7fffffff 00000001 00000004 00000000 0 0 0 00000000 00000000 1 0a 80000000
0 1 00225822 00000003 00000005 00000008 00000000 0 0 0 00000000 00000000 1 0b fffffffe
0 1 00226027 0f0f0000 000000f0 0000000c 00000000 0 0 0 00000000 00000000 1 0c f0f0ff0f
0 1 0022682a ffffffff 00000001 00000010 00000000 0 0 0 00000000 00000000 1 0d 00000001
0 1 0022702b ffffffff 00000001 00000014 00000000 0 0 0 00000000 00000000 1 0e 00000000
0 1 00027903 00000000 80000010 00000018 00000000 0 0 0 00000000 00000000 1 0f f8000001
1 1 00028200 00000000 00ff00ff 0000001c 00000000 0 0 0 00000000 00000000 1 10 ff00ff00
// immediate forms addi andi ori slti lui
0 1 2023fffc 00000010 00000000 00000020 00000000 0 0 0 00000000 00000000 1 03 0000000c
0 1 3024ff00 1234abcd 00000000 00000024 00000000 0 0 0 00000000 00000000 1 04 0000ab00
0 1 34258001 00010000 00000000 00000028 00000000 0 0 0 00000000 00000000 1 05 00018001
0 1 2826ffff fffffffe 00000000 0000002c 00000000 0 0 0 00000000 00000000 1 06 00000001
1 1 3c071234 00000000 00000000 00000030 00000000 0 0 0 00000000 00000000 1 07 12340000
// forwarding, stale register values are deadbeef
0 1 20280005 00000010 00000000 00000034 00000000 0 0 0 00000000 00000000 1 08 00000015
0 1 01084820 deadbeef deadbeef 00000038 00000000 0 0 0 00000000 00000000 1 09 0000002a
0 1 01285022 deadbeef deadbeef 0000003c 00000000 0 0 0 00000000 00000000 1 0a 00000015
0 1 340b0001 00000000 00000000 00000040 00000000 0 0 0 00000000 00000000 1 0b 00000001
0 1 340b0002 00000000 00000000 00000044 00000000 0 0 0 00000000 00000000 1 0b 00000002
0 1 016b6020 deadbeef deadbeef 00000048 00000000 0 0 0 00000000 00000000 1 0c 00000004
0 1 20200055 00000100 00000000 0000004c 00000000 0 0 0 00000000 00000000 0 00 00000000
1 1 00006820 00000000 00000000 00000050 00000000 0 0 0 00000000 00000000 1 0d 00000000
// memory port, load forwarding
0 1 ac220008 00001000 cafef00d 00000054 00000000 0 0 1 00001008 cafef00d 0 00 00000000
0 1 8c23fffc 00002000 00000000 00000058 11223344 0 1 0 00001ffc 00000000 1 03 11223344
0 1 00622020 deadbeef 00000010 0000005c 00000000 0 0 0 00000000 00000000 1 04 11223354
1 1 ac640000 deadbeef deadbeef 00000060 00000000 0 0 1 11223344 11223354 0 00 00000000
// branches, bubble and jal
0 1 10220010 00000055 00000055 00000064 00000000 1 0 0 00000000 00000000 0 00 00000000
0 1 14220010 00000055 00000055 00000068 00000000 0 0 0 00000000 00000000 0 00 00000000
0 0 00000000 00000000 00000000 00000000 00000000 0 0 0 00000000 00000000 0 00 00000000
0 1 2005fffd 00000000 00000000 0000006c 00000000 0 0 0 00000000 00000000 1 05 fffffffd
0 1 18a00008 00000001 00000000 00000070 00000000 1 0 0 00000000 00000000 0 00 00000000
0 1 1ca00008 00000001 00000000 00000074 00000000 0 0 0 00000000 00000000 0 00 00000000
0 1 0c000040 00000000 00000000 00400018 00000000 0 0 0 00000000 00000000 1 1f 00400018
1 1 1c200008 00000010 00000000 0040001c 00000000 1 0 0 00000000 00000000 0 00 00000000

// ==== mips_ex.f ====
mips_ex_isa_pkg.sv
mips_ex_ctl_pkg.sv
ex_instr_decoder.sv
ex_forward_unit.sv
ex_alu.sv
ex_branch_compare.sv
ex_stage.sv
ex_mem_wb_regs.sv
ex_top.sv
tb_ex_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ex_top -f mips_ex.f \
	|| { echo "verilator build failed"; exit 1; }
out="$(./obj_dir/Vtb_ex_top)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1
